//--- hdl/wdg_crc8.sv
/*
 * Parallel CRC-8 over one 16-bit scan word, MSB first.
 * No reflection and no final XOR; purely combinational.
 */
`timescale 1ns/1ns
`default_nettype none

module wdg_crc8
    import wdg_pkg::*;
(
    input  wire logic [2*REG_DW-1:0]  i_word,
    output logic      [REG_CRC_W-1:0] o_crc
);

    always_comb begin
        logic [REG_CRC_W-1:0] crc;
        logic                 fb;

        crc = CRC_INIT;
        // one shift per input bit, top bit first
        for (int i = 2*REG_DW-1; i >= 0; i--) begin
            fb  = crc[REG_CRC_W-1] ^ i_word[i];
            crc = {crc[REG_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
        o_crc = crc;
    end

endmodule

`default_nettype wire

//--- hdl/wdg_link_monitor.sv
/*
 * One-wire link watchdog. Requests a transmission every refresh period
 * or on a state-machine request, then checks that responses keep coming.
 */
`timescale 1ns/1ns
`default_nettype none

module wdg_link_monitor
    import wdg_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_link_en,
    input  wire logic [1:0] i_refresh_sel,
    input  wire logic [1:0] i_tmo_sel,
    input  wire logic       i_fsm_tx_req,
    output logic            o_link_tx_req,
    input  wire logic       i_link_tx_ack,
    input  wire logic       i_spi_rst_wdg,
    input  wire logic       i_link_rx_rsp,
    output logic            o_wdg_timeout_err
);

    logic [WDG_CNT_W-1:0] refresh_cnt;
    logic                 refresh_hit;
    logic                 fsm_req_q;
    logic                 fsm_launch;
    logic                 in_flight;
    logic [WDG_CNT_W-1:0] tmo_cnt;
    logic                 tmo_hit;

    assign refresh_hit = i_link_en && (refresh_cnt == wdg_period(i_refresh_sel) - 1'b1);
    assign tmo_hit     = in_flight && (tmo_cnt == wdg_period(i_tmo_sel) - 1'b1);

    // ================================================
    // refresh request
    // ================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            refresh_cnt <= '0;
        end else if (!i_link_en || o_link_tx_req || i_link_tx_ack || i_spi_rst_wdg ||
                     refresh_hit) begin
            refresh_cnt <= '0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // fsm request counts on its rising edge only
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fsm_req_q <= 1'b0;
        end else begin
            fsm_req_q <= i_fsm_tx_req;
        end
    end

    assign fsm_launch = i_fsm_tx_req & ~fsm_req_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_link_tx_req <= 1'b0;
        end else if (!i_link_en || i_link_tx_ack) begin
            o_link_tx_req <= 1'b0;
        end else if (refresh_hit || fsm_launch) begin
            o_link_tx_req <= 1'b1;
        end
    end

    // ================================================
    // response timeout
    // ================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in_flight <= 1'b0;
        end else if (!i_link_en || tmo_hit) begin
            in_flight <= 1'b0;
        end else if (o_link_tx_req || i_spi_rst_wdg) begin
            in_flight <= 1'b1;
        end
    end

    // each response restarts the window
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tmo_cnt <= '0;
        end else if (!in_flight || i_link_rx_rsp || tmo_hit) begin
            tmo_cnt <= '0;
        end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wdg_timeout_err <= 1'b0;
        end else begin
            o_wdg_timeout_err <= tmo_hit;
        end
    end

    a_no_req_when_off: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$past(i_link_en) |-> !o_link_tx_req);

endmodule

`default_nettype wire

//--- hdl/wdg_pkg.sv
/*
 * Shared constants, scan address list and bus structs for the watchdog
 * subsystem. Every watchdog module takes it by wildcard import.
 */
`default_nettype none

package wdg_pkg;

    // ================================================
    // timing
    // ================================================
    // 250 us at 48 MHz
    localparam int WDG_BASE_CYC = 12000;
    localparam int WDG_CNT_W    = $clog2(8 * WDG_BASE_CYC);

    // ================================================
    // register scan
    // ================================================
    localparam int SCAN_REG_NUM = 8;
    localparam int SCAN_PTR_W   = $clog2(SCAN_REG_NUM);
    localparam int REG_AW       = 7;
    localparam int REG_DW       = 8;
    localparam int REG_CRC_W    = 8;

    // scan order, entry 0 first
    localparam logic [REG_AW-1:0] SCAN_REG_ADDR [SCAN_REG_NUM] = '{
        7'h01, 7'h02, 7'h03, 7'h08, 7'h09, 7'h0A, 7'h0B, 7'h30
    };

    localparam logic [REG_CRC_W-1:0] CRC_POLY = 8'h07;
    localparam logic [REG_CRC_W-1:0] CRC_INIT = 8'hFF;

    typedef struct packed {
        logic [1:0] tmo_sel;
        logic [1:0] refresh_sel;
        logic [1:0] scan_sel;
    } wdg_cfg_t;

    typedef struct packed {
        logic                 wr_en;
        logic [REG_AW-1:0]    addr;
        logic [REG_DW-1:0]    data;
        logic [REG_CRC_W-1:0] crc;
    } reg_wr_t;

    typedef struct packed {
        logic              req;
        logic [REG_AW-1:0] addr;
    } scan_rd_t;

    typedef struct packed {
        logic                 ack;
        logic [REG_DW-1:0]    data;
        logic [REG_CRC_W-1:0] crc;
    } scan_rsp_t;

    // select 0..3 gives 1, 2, 4 or 8 base periods
    function automatic logic [WDG_CNT_W-1:0] wdg_period(input logic [1:0] sel);
        return WDG_CNT_W'(WDG_BASE_CYC) << sel;
    endfunction

endpackage

`default_nettype wire

//--- hdl/wdg_reg_bank.sv
/*
 * Eight-slot bank of the scanned configuration registers. The host writes
 * data plus CRC; the scanner reads a slot and gets one ack pulse back.
 */
`timescale 1ns/1ns
`default_nettype none

module wdg_reg_bank
    import wdg_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire reg_wr_t   i_wr,
    input  wire scan_rd_t  i_rd,
    output scan_rsp_t      o_rsp
);

    logic [REG_DW-1:0]    slot_data [SCAN_REG_NUM];
    logic [REG_CRC_W-1:0] slot_crc  [SCAN_REG_NUM];
    logic                 wr_hit;
    logic [SCAN_PTR_W-1:0] wr_slot;
    logic [SCAN_PTR_W-1:0] rd_slot;
    logic [SCAN_PTR_W-1:0] rd_slot_q;
    logic                 req_q;
    logic                 rd_pend;
    logic                 rsp_ack;
    logic [REG_DW-1:0]    rsp_data;
    logic [REG_CRC_W-1:0] rsp_crc;

    // address to slot, through the scan list
    always_comb begin
        wr_hit  = 1'b0;
        wr_slot = '0;
        rd_slot = '0;
        for (int i = 0; i < SCAN_REG_NUM; i++) begin
            if (i_wr.addr == SCAN_REG_ADDR[i]) begin
                wr_hit  = 1'b1;
                wr_slot = SCAN_PTR_W'(i);
            end
            if (i_rd.addr == SCAN_REG_ADDR[i]) begin
                rd_slot = SCAN_PTR_W'(i);
            end
        end
    end

    // ================================================
    // host write port
    // ================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < SCAN_REG_NUM; i++) begin
                slot_data[i] <= '0;
                slot_crc[i]  <= '0;
            end
        end else if (i_wr.wr_en && wr_hit) begin
            slot_data[wr_slot] <= i_wr.data;
            slot_crc[wr_slot]  <= i_wr.crc;
        end
    end

    // ================================================
    // scan read port
    // ================================================
    // rising edge of req marks a new read, so a held req acks once
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_q   <= 1'b0;
            rd_pend <= 1'b0;
            rsp_ack <= 1'b0;
        end else begin
            req_q   <= i_rd.req;
            rd_pend <= i_rd.req & ~req_q;
            // a request dropped meanwhile gets no ack
            rsp_ack <= rd_pend & i_rd.req;
        end
    end

    always_ff @(posedge i_clk) begin
        rd_slot_q <= rd_slot;
        rsp_data  <= slot_data[rd_slot_q];
        rsp_crc   <= slot_crc[rd_slot_q];
    end

    assign o_rsp = '{ack: rsp_ack, data: rsp_data, crc: rsp_crc};

    a_ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rsp.ack |-> $past(i_rd.req));

endmodule

`default_nettype wire

//--- hdl/wdg_reg_scan.sv
/*
 * Register scanner. Reads one register from the scan list per scan
 * period, recomputes its CRC and pulses o_scan_crc_err on a mismatch.
 */
`timescale 1ns/1ns
`default_nettype none

module wdg_reg_scan
    import wdg_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_scan_en,
    input  wire logic [1:0] i_scan_sel,
    output scan_rd_t        o_rd,
    input  wire scan_rsp_t  i_rsp,
    output logic            o_scan_crc_err
);

    logic [WDG_CNT_W-1:0]  scan_cnt;
    logic [WDG_CNT_W-1:0]  scan_last;
    logic                  scan_hit;
    logic [SCAN_PTR_W-1:0] scan_ptr;
    logic                  rd_req;
    logic [REG_AW-1:0]     rd_addr;
    logic [2*REG_DW-1:0]   crc_word;
    logic [REG_CRC_W-1:0]  crc_calc;

    assign scan_last = wdg_period(i_scan_sel) - 1'b1;
    assign scan_hit  = i_scan_en && (scan_cnt == scan_last);

    // ================================================
    // scan period counter
    // ================================================
    // held at zero while a read is outstanding
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_cnt <= '0;
        end else if (!i_scan_en || rd_req || i_rsp.ack || scan_hit) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // pointer into the scan list, wraps after the last entry
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_ptr <= '0;
        end else if (scan_hit) begin
            if (scan_ptr == SCAN_PTR_W'(SCAN_REG_NUM - 1)) begin
                scan_ptr <= '0;
            end else begin
                scan_ptr <= scan_ptr + 1'b1;
            end
        end
    end

    // ================================================
    // read request
    // ================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_req <= 1'b0;
        end else if (!i_scan_en || i_rsp.ack) begin
            rd_req <= 1'b0;
        end else if (scan_hit) begin
            rd_req <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (scan_hit) begin
            rd_addr <= SCAN_REG_ADDR[scan_ptr];
        end
    end

    assign o_rd = '{req: rd_req, addr: rd_addr};

    // ================================================
    // CRC check
    // ================================================
    // marker bit, then address, then data
    assign crc_word = {1'b1, rd_addr, i_rsp.data};

    wdg_crc8 u_crc8 (
        .i_word (crc_word),
        .o_crc  (crc_calc)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_scan_crc_err <= 1'b0;
        end else begin
            o_scan_crc_err <= i_rsp.ack && (i_rsp.crc != crc_calc);
        end
    end

    a_no_req_rise_on_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(rd_req) |-> !i_rsp.ack);

    a_err_after_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_scan_crc_err |-> $past(i_rsp.ack));

endmodule

`default_nettype wire

//--- hdl/wdg_subsys.sv
/*
 * Watchdog subsystem top. Joins the register bank, the register scanner
 * and the link monitor, and splits the config word among them.
 */
`timescale 1ns/1ns
`default_nettype none

module wdg_subsys
    import wdg_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire wdg_cfg_t  i_cfg,
    input  wire logic      i_scan_en,
    input  wire logic      i_link_en,
    input  wire reg_wr_t   i_wr,
    output logic           o_scan_crc_err,
    output scan_rd_t       o_scan_rd,
    input  wire logic      i_fsm_tx_req,
    output logic           o_link_tx_req,
    input  wire logic      i_link_tx_ack,
    input  wire logic      i_spi_rst_wdg,
    input  wire logic      i_link_rx_rsp,
    output logic           o_wdg_timeout_err
);

    scan_rsp_t scan_rsp;

    wdg_reg_bank u_reg_bank (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wr    (i_wr),
        .i_rd    (o_scan_rd),
        .o_rsp   (scan_rsp)
    );

    wdg_reg_scan u_reg_scan (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_scan_en      (i_scan_en),
        .i_scan_sel     (i_cfg.scan_sel),
        .o_rd           (o_scan_rd),
        .i_rsp          (scan_rsp),
        .o_scan_crc_err (o_scan_crc_err)
    );

    wdg_link_monitor u_link_monitor (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_link_en         (i_link_en),
        .i_refresh_sel     (i_cfg.refresh_sel),
        .i_tmo_sel         (i_cfg.tmo_sel),
        .i_fsm_tx_req      (i_fsm_tx_req),
        .o_link_tx_req     (o_link_tx_req),
        .i_link_tx_ack     (i_link_tx_ack),
        .i_spi_rst_wdg     (i_spi_rst_wdg),
        .i_link_rx_rsp     (i_link_rx_rsp),
        .o_wdg_timeout_err (o_wdg_timeout_err)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the watchdog testbench with Verilator, run it, and look for the
# pass message in its output.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=tb_wdg_subsys

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f wdg_subsys.f --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$("./$BUILD_DIR/$TOP")
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "No errors"; then
    exit 0
fi

echo "pass message not found"
exit 1

//--- testbench/tb_wdg_subsys.sv
/*
 * Self-checking testbench for the watchdog subsystem. Models the host and
 * the link peer, checks scan reads, CRC errors, refresh requests and
 * response timeouts against its own reference model.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_wdg_subsys
    import wdg_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    // base periods used by all tests, then some slack
    localparam int TEST_BASE_PERIODS = 16 + 8 + 30 + 4 + 9;
    localparam int MARGIN_PERIODS    = 8;
    localparam logic [6:0] ADDR_LIST [8] = '{
        7'h01, 7'h02, 7'h03, 7'h08, 7'h09, 7'h0A, 7'h0B, 7'h30
    };

    logic     clk;
    logic     rst_n;
    wdg_cfg_t cfg;
    logic     scan_en;
    logic     link_en;
    reg_wr_t  wr;
    logic     scan_crc_err;
    scan_rd_t scan_rd;
    logic     fsm_tx_req;
    logic     link_tx_req;
    logic     link_tx_ack;
    logic     spi_rst_wdg;
    logic     link_rx_rsp;
    logic     timeout_err;

    // host's copy of the register bank
    logic [7:0] reg_data [8];
    logic [7:0] reg_crc  [8];

    int   cyc;
    int   errors;
    int   test_err_base;
    int   tests_run;
    int   tests_failed;
    int   rd_idx;
    int   cur_slot;
    int   rise_cnt;
    int   rise_cyc;
    int   rise_gap;
    int   err_pulses;
    logic prev_req;
    int   tx_rise_cnt;
    int   tx_rise_cyc;
    int   tx_fall_cyc;
    int   tmo_pulses;
    int   tmo_rise_cyc;
    logic prev_tx_req;
    logic prev_ack;
    logic prev_tmo;
    logic tmo_allowed;
    logic peer_on;
    int   rsp_period;

    wdg_subsys uut (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_cfg             (cfg),
        .i_scan_en         (scan_en),
        .i_link_en         (link_en),
        .i_wr              (wr),
        .o_scan_crc_err    (scan_crc_err),
        .o_scan_rd         (scan_rd),
        .i_fsm_tx_req      (fsm_tx_req),
        .o_link_tx_req     (link_tx_req),
        .i_link_tx_ack     (link_tx_ack),
        .i_spi_rst_wdg     (spi_rst_wdg),
        .i_link_rx_rsp     (link_rx_rsp),
        .o_wdg_timeout_err (timeout_err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // ==================================================
    // reference model
    // ==================================================
    // CRC-8, poly 07, init FF, one byte at a time, high byte first
    function automatic logic [7:0] crc8_ref(input logic [15:0] word);
        logic [7:0] crc;
        crc = 8'hFF;
        for (int b = 1; b >= 0; b--) begin
            crc = crc ^ word[b*8 +: 8];
            for (int k = 0; k < 8; k++) begin
                crc = crc[7] ? ((crc << 1) ^ 8'h07) : (crc << 1);
            end
        end
        return crc;
    endfunction

    function automatic int period_cycles(input logic [1:0] sel);
        return WDG_BASE_CYC * (1 << sel);
    endfunction

    function automatic logic crc_bad(input int slot);
        return crc8_ref({1'b1, ADDR_LIST[slot], reg_data[slot]}) != reg_crc[slot];
    endfunction

    // ==================================================
    // checks
    // ==================================================
    task automatic check_rd(input string name, input scan_rd_t exp, input scan_rd_t got);
        if (got !== exp) begin
            $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("FAILED t=%0t %s expected=%b actual=%b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp) begin
            $display("FAILED t=%0t %s expected=%0d actual=%0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %0d, %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d, %s: FAIL", tests_run, name);
        end
        test_err_base = errors;
    endtask

    // ==================================================
    // stimulus helpers
    // ==================================================
    // leaves the caller just after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic write_reg(input int slot, input logic corrupt);
        logic [7:0] data;
        logic [7:0] crc;
        data = 8'($urandom);
        crc  = crc8_ref({1'b1, ADDR_LIST[slot], data});
        if (corrupt) begin
            crc = crc ^ 8'h5A;
        end
        wr = '{wr_en: 1'b1, addr: ADDR_LIST[slot], data: data, crc: crc};
        wait_cycles(1);
        wr.wr_en = 1'b0;
        reg_data[slot] = data;
        reg_crc[slot]  = crc;
    endtask

    // stop between reads so no ack is lost
    task automatic stop_scan();
        while (scan_rd.req) begin
            wait_cycles(1);
        end
        scan_en = 1'b0;
        wait_cycles(1);
    endtask

    task automatic restart_link();
        link_en = 1'b0;
        wait_cycles(1);
        link_en = 1'b1;
    endtask

    task automatic fsm_pulse();
        fsm_tx_req = 1'b1;
        wait_cycles(1);
        fsm_tx_req = 1'b0;
    endtask

    // ==================================================
    // link peer
    // ==================================================
    initial begin : peer_ack
        forever begin
            @(negedge clk);
            if (rst_n && link_tx_req && peer_on) begin
                @(posedge clk);
                #DRIVE_DLY link_tx_ack = 1'b1;
                @(posedge clk);
                #DRIVE_DLY link_tx_ack = 1'b0;
            end
        end
    end

    // periodic responses, off while rsp_period is 0
    initial begin : peer_rsp
        int since_rsp;
        since_rsp = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (rsp_period > 0 && since_rsp >= rsp_period - 1) begin
                link_rx_rsp = 1'b1;
                since_rsp   = 0;
            end else begin
                link_rx_rsp = 1'b0;
                since_rsp   = (rsp_period > 0) ? since_rsp + 1 : 0;
            end
        end
    end

    // ==================================================
    // monitors
    // ==================================================
    always @(negedge clk) begin : scan_monitor
        scan_rd_t exp_rd;
        logic     exp_err;
        if (rst_n) begin
            if (scan_rd.req && !prev_req) begin
                exp_rd = '{req: 1'b1, addr: ADDR_LIST[rd_idx]};
                check_rd("o_scan_rd", exp_rd, scan_rd);
                cur_slot = rd_idx;
                rd_idx   = (rd_idx + 1) % SCAN_REG_NUM;
                rise_gap = cyc - rise_cyc;
                rise_cyc = cyc;
                rise_cnt++;
            end
            // req drops on the edge after ack, together with the error flag
            exp_err = prev_req && !scan_rd.req && crc_bad(cur_slot);
            check_bit("o_scan_crc_err", exp_err, scan_crc_err);
            if (scan_crc_err) begin
                err_pulses++;
            end
        end
        prev_req = scan_rd.req;
    end

    always @(negedge clk) begin : link_monitor
        if (rst_n) begin
            if (link_tx_req && !prev_tx_req) begin
                tx_rise_cyc = cyc;
                tx_rise_cnt++;
            end
            if (!link_tx_req && prev_tx_req) begin
                tx_fall_cyc = cyc;
                if (link_en && !prev_ack) begin
                    $display("ERROR t=%0t: link request dropped without an ack", $time);
                    errors++;
                end
            end
            if (timeout_err && !prev_tmo) begin
                tmo_pulses++;
                tmo_rise_cyc = cyc;
            end
            if (timeout_err && (prev_tmo || !tmo_allowed)) begin
                $display("ERROR t=%0t: timeout pulse where none was due", $time);
                errors++;
            end
        end
        prev_tx_req = link_tx_req;
        prev_ack    = link_tx_ack;
        prev_tmo    = timeout_err;
    end

    initial begin : watchdog
        #((TEST_BASE_PERIODS + MARGIN_PERIODS) * WDG_BASE_CYC * CLK_PERIOD);
        $display("ERROR: run stopped by the watchdog, a test never finished");
        $display("Errors found");
        $finish;
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : main
        int target;
        int base;
        int launch_cyc;
        int tmo;
        void'($urandom(32'h2daf_a84a));
        clk = 1'b0;
        rst_n = 1'b0;
        cfg = '{tmo_sel: 2'd3, refresh_sel: 2'd0, scan_sel: 2'd0};
        scan_en = 1'b0;
        link_en = 1'b0;
        wr = '0;
        fsm_tx_req = 1'b0;
        link_tx_ack = 1'b0;
        spi_rst_wdg = 1'b0;
        link_rx_rsp = 1'b0;
        cyc = 0;
        errors = 0;
        test_err_base = 0;
        tests_run = 0;
        tests_failed = 0;
        rd_idx = 0;
        cur_slot = 0;
        rise_cnt = 0;
        rise_cyc = 0;
        rise_gap = 0;
        err_pulses = 0;
        prev_req = 1'b0;
        tx_rise_cnt = 0;
        tx_rise_cyc = 0;
        tx_fall_cyc = 0;
        tmo_pulses = 0;
        tmo_rise_cyc = 0;
        prev_tx_req = 1'b0;
        prev_ack = 1'b0;
        prev_tmo = 1'b0;
        tmo_allowed = 1'b0;
        peer_on = 1'b1;
        rsp_period = 0;
        for (int i = 0; i < 8; i++) begin
            reg_data[i] = '0;
            reg_crc[i]  = '0;
        end
        repeat (16) @(posedge clk);
        #DRIVE_DLY rst_n = 1'b1;
        wait_cycles(2);

        // two rotations over good registers
        for (int i = 0; i < 8; i++) begin
            write_reg(i, 1'b0);
        end
        base = err_pulses;
        target = rise_cnt + 16;
        scan_en = 1'b1;
        wait (rise_cnt == target);
        stop_scan();
        check_count("o_scan_crc_err pulses", base, err_pulses);
        finish_test("good registers, no error");

        // slot 5 (address 0A) with a corrupted CRC
        write_reg(5, 1'b1);
        base = err_pulses;
        target = rise_cnt + 8;
        scan_en = 1'b1;
        wait (rise_cnt == target);
        stop_scan();
        check_count("o_scan_crc_err pulses", base + 1, err_pulses);
        finish_test("bad CRC detected");

        for (int s = 0; s < 4; s++) begin
            cfg.scan_sel = 2'(s);
            target = rise_cnt + 2;
            scan_en = 1'b1;
            wait (rise_cnt == target);
            check_count("scan request spacing", period_cycles(2'(s)) + 3, rise_gap);
            wait_cycles(1);
            stop_scan();
        end
        finish_test("scan period follows config");

        // refresh at base period, responses keep the long timeout away
        cfg.refresh_sel = 2'd0;
        cfg.tmo_sel = 2'd3;
        rsp_period = period_cycles(2'd3) / 2;
        target = tx_rise_cnt + 2;
        link_en = 1'b1;
        wait (tx_rise_cnt == target);
        check_count("refresh spacing", period_cycles(2'd0), tx_rise_cyc - tx_fall_cyc);
        wait_cycles(1);
        while (link_tx_req) begin
            wait_cycles(1);
        end
        wait_cycles(100);
        fsm_tx_req = 1'b1;
        launch_cyc = cyc;
        target = tx_rise_cnt + 1;
        wait (tx_rise_cnt == target);
        check_count("fsm request delay", 1, tx_rise_cyc - launch_cyc);
        target = tx_rise_cnt + 1;
        wait (tx_rise_cnt == target);
        check_count("refresh spacing, fsm held", period_cycles(2'd0),
                    tx_rise_cyc - tx_fall_cyc);
        wait_cycles(1);
        fsm_tx_req = 1'b0;
        rsp_period = 0;
        link_en = 1'b0;
        wait_cycles(2);
        finish_test("refresh request");

        // no responses at all
        cfg.tmo_sel = 2'd0;
        cfg.refresh_sel = 2'd3;
        tmo = period_cycles(2'd0);
        restart_link();
        tmo_allowed = 1'b1;
        base = tmo_pulses;
        target = tx_rise_cnt + 1;
        fsm_pulse();
        wait (tx_rise_cnt == target);
        wait (tmo_pulses == base + 1);
        check_count("timeout delay", tmo + 1, tmo_rise_cyc - tx_rise_cyc);
        wait_cycles(2 * tmo);
        check_count("timeout pulses", base + 1, tmo_pulses);
        tmo_allowed = 1'b0;
        // response every half timeout period
        rsp_period = tmo / 2;
        restart_link();
        target = tx_rise_cnt + 1;
        fsm_pulse();
        wait (tx_rise_cnt == target);
        wait_cycles(3 * tmo);
        check_count("timeout pulses", base + 1, tmo_pulses);
        // request left unacked, then link switched off
        rsp_period = 0;
        peer_on = 1'b0;
        restart_link();
        target = tx_rise_cnt + 1;
        fsm_pulse();
        wait (tx_rise_cnt == target);
        wait_cycles(tmo / 2);
        link_en = 1'b0;
        wait_cycles(1);
        check_bit("o_link_tx_req", 1'b0, link_tx_req);
        wait_cycles(2 * tmo);
        check_count("timeout pulses", base + 1, tmo_pulses);
        peer_on = 1'b1;
        finish_test("timeout");

        $display("%0d tests, %0d failed, %0d check failures", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wdg_subsys.f
hdl/wdg_pkg.sv
hdl/wdg_crc8.sv
hdl/wdg_reg_bank.sv
hdl/wdg_reg_scan.sv
hdl/wdg_link_monitor.sv
hdl/wdg_subsys.sv
testbench/tb_wdg_subsys.sv
